// File: verilog/token_engine_macros.svh
`ifndef TOKEN_ENGINE_MACROS_SVH
`define TOKEN_ENGINE_MACROS_SVH

// lanes in the MAC array
`define NUM_LANES 4

// GLB port widths
`define GLB_AW 16
`define GLB_DW 32

// reads allowed in flight before issue stalls
`define MAX_OUTSTANDING 4

// word counters for the stream phase
`define CNT_W 16

`endif

// File: verilog/engine_cfg_pkg.sv
`include "token_engine_macros.svh"

package engine_cfg_pkg;

    typedef enum logic [1:0] {
        LAYER_CONV = 2'd0,
        LAYER_FC   = 2'd1
    } layer_kind_e;

    // conv view of the descriptor word
    typedef struct packed {
        layer_kind_e kind;
        logic [3:0]  oc_real;
        logic [7:0]  in_c;
        logic [7:0]  in_r;
        logic [9:0]  spare;
    } conv_desc_t;

    // fc view, kind and oc_real line up with the conv view
    typedef struct packed {
        layer_kind_e kind;
        logic [3:0]  oc_real;
        logic [15:0] in_len;
        logic [9:0]  spare;
    } fc_desc_t;

    typedef union packed {
        conv_desc_t conv;
        fc_desc_t   fc;
    } pass_desc_u;

    typedef struct packed {
        pass_desc_u          desc;
        logic [`GLB_AW-1:0]  weight_base;
        logic [`GLB_AW-1:0]  ifmap_base;
        logic [`GLB_AW-1:0]  opsum_base;
    } pass_cmd_t;

    typedef struct packed {
        layer_kind_e                kind;
        logic [`CNT_W-1:0]          stream_words;
        logic [`NUM_LANES-1:0]      lane_mask;
        logic [`NUM_LANES-1:0][1:0] byte_select;   // byte of the ifmap word per lane
        logic [`GLB_AW-1:0]         weight_base;
        logic [`GLB_AW-1:0]         ifmap_base;
        logic [`GLB_AW-1:0]         opsum_base;
    } pass_cfg_t;

endpackage

// File: verilog/glb_bus_pkg.sv
`include "token_engine_macros.svh"

package glb_bus_pkg;

    // one request word, reads have we low
    typedef struct packed {
        logic               we;
        logic [`GLB_AW-1:0] addr;
        logic [`GLB_DW-1:0] wdata;
    } glb_req_t;

    typedef struct packed {
        logic [`GLB_DW-1:0] rdata;
    } glb_rsp_t;

    // what a read response is for
    typedef enum logic {
        TAG_WEIGHT = 1'b0,
        TAG_STREAM = 1'b1
    } rsp_tag_e;

endpackage

// File: verilog/pass_decoder.sv
`timescale 1ns/1ps
`include "token_engine_macros.svh"

module pass_decoder
    import engine_cfg_pkg::*;
(
    input  logic      clk,
    input  logic      rst_i,
    input  logic      cmd_valid_i,
    output logic      cmd_ready_o,
    input  pass_cmd_t cmd_i,
    input  logic      busy_i,
    output pass_cfg_t cfg_o,
    output logic      start_o
);

    pass_desc_u        desc;
    layer_kind_e       kind;
    logic [3:0]        oc_real;
    logic [`CNT_W-1:0] in_c_ext;
    logic [`CNT_W-1:0] in_r_ext;
    pass_cfg_t         cfg_d;
    logic              cmd_fire;

    assign desc    = cmd_i.desc;
    assign kind    = desc.conv.kind;     // same bits in the fc view
    assign oc_real = desc.conv.oc_real;

    // start_o covers the cycle before the sequencer reports busy
    assign cmd_ready_o = !busy_i && !start_o;
    assign cmd_fire    = cmd_valid_i && cmd_ready_o;

    always_comb begin
        in_c_ext = desc.conv.in_c;
        in_r_ext = desc.conv.in_r;

        cfg_d.kind        = kind;
        cfg_d.weight_base = cmd_i.weight_base;
        cfg_d.ifmap_base  = cmd_i.ifmap_base;
        cfg_d.opsum_base  = cmd_i.opsum_base;

        if (kind == LAYER_FC) begin
            cfg_d.stream_words = desc.fc.in_len;
        end else begin
            cfg_d.stream_words = in_c_ext * in_r_ext;   // one word per pixel
        end

        for (int l = 0; l < `NUM_LANES; l++) begin
            cfg_d.lane_mask[l]   = (l < oc_real);        // saturates at all lanes
            cfg_d.byte_select[l] = (kind == LAYER_FC) ? 2'd0 : 2'(l);
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            start_o <= 1'b0;
        end else begin
            start_o <= cmd_fire;
        end
    end

    // config holds until the next accepted command
    always_ff @(posedge clk) begin
        if (cmd_fire) begin
            cfg_o <= cfg_d;
        end
    end

    // accepted command starts the sequencer, which then blocks a second one
    a_accept_then_busy: assert property (@(posedge clk) disable iff (rst_i)
        cmd_fire |=> start_o ##1 (busy_i && !cmd_fire));

endmodule

// File: verilog/phase_sequencer.sv
`timescale 1ns/1ps
`include "token_engine_macros.svh"

module phase_sequencer
    import engine_cfg_pkg::*;
    import glb_bus_pkg::*;
(
    input  logic                               clk,
    input  logic                               rst_i,
    input  logic                               start_i,
    input  pass_cfg_t                          cfg_i,
    input  logic [`NUM_LANES-1:0][`GLB_DW-1:0] acc_i,
    input  logic                               tracker_idle_i,
    output logic                               issue_valid_o,
    input  logic                               issue_ready_i,
    output glb_req_t                           issue_req_o,
    output rsp_tag_e                           issue_tag_o,
    output logic                               clear_acc_o,
    output logic                               busy_o,
    output logic                               pass_done_o
);

    localparam int LANE_W = $clog2(`NUM_LANES);

    typedef enum logic [2:0] {
        IDLE,
        LOAD_WEIGHT,
        STREAM,
        WAIT_DRAIN,
        WRITEBACK,
        DONE
    } state_e;

    state_e                state_q;
    logic [`CNT_W-1:0]     cnt_q;       // words issued in this phase
    logic [`NUM_LANES-1:0] pend_q;      // lanes still to write back
    logic [LANE_W-1:0]     wb_lane;
    logic                  issue_fire;
    logic                  last_weight;
    logic                  last_word;
    logic                  last_lane;

    assign issue_fire  = issue_valid_o && issue_ready_i;
    assign last_weight = (cnt_q == (`NUM_LANES - 1));
    assign last_word   = (cnt_q == cfg_i.stream_words - 1'b1);
    assign last_lane   = ((pend_q & (pend_q - 1'b1)) == '0);   // one bit left

    // lowest pending lane, masked lanes never enter pend_q
    always_comb begin
        wb_lane = '0;
        for (int l = `NUM_LANES - 1; l >= 0; l--) begin
            if (pend_q[l]) begin
                wb_lane = LANE_W'(l);
            end
        end
    end

    always_comb begin
        issue_valid_o = 1'b0;
        issue_req_o   = '0;
        issue_tag_o   = TAG_STREAM;
        case (state_q)
            LOAD_WEIGHT: begin
                issue_valid_o    = 1'b1;
                issue_req_o.addr = cfg_i.weight_base + cnt_q;
                issue_tag_o      = TAG_WEIGHT;
            end
            STREAM: begin
                issue_valid_o    = 1'b1;
                issue_req_o.addr = cfg_i.ifmap_base + cnt_q;
            end
            WRITEBACK: begin
                issue_valid_o     = |pend_q;
                issue_req_o.we    = 1'b1;
                issue_req_o.addr  = cfg_i.opsum_base + wb_lane;
                issue_req_o.wdata = acc_i[wb_lane];
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= IDLE;
            cnt_q   <= '0;
            pend_q  <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        state_q <= LOAD_WEIGHT;
                        cnt_q   <= '0;
                    end
                end
                LOAD_WEIGHT: begin
                    if (issue_fire) begin
                        cnt_q <= last_weight ? '0 : cnt_q + 1'b1;
                        if (last_weight) begin
                            state_q <= (cfg_i.stream_words == '0) ? WAIT_DRAIN : STREAM;
                        end
                    end
                end
                STREAM: begin
                    if (issue_fire) begin
                        cnt_q <= cnt_q + 1'b1;
                        if (last_word) state_q <= WAIT_DRAIN;
                    end
                end
                WAIT_DRAIN: begin
                    // all reads back, accumulators settle the same cycle
                    if (tracker_idle_i) begin
                        state_q <= WRITEBACK;
                        pend_q  <= cfg_i.lane_mask;
                    end
                end
                WRITEBACK: begin
                    if (pend_q == '0) begin
                        state_q <= DONE;             // no active lanes
                    end else if (issue_fire) begin
                        pend_q <= pend_q & (pend_q - 1'b1);
                        if (last_lane) state_q <= DONE;
                    end
                end
                DONE: state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    assign clear_acc_o = (state_q == IDLE) && start_i;
    assign busy_o      = (state_q != IDLE);
    assign pass_done_o = (state_q == DONE);

    // a stalled request must not move until the GLB takes it
    a_issue_stable: assert property (@(posedge clk) disable iff (rst_i)
        issue_valid_o && !issue_ready_i |=>
            issue_valid_o && $stable(issue_req_o) && $stable(issue_tag_o));

endmodule

// File: verilog/lane_mac_array.sv
`timescale 1ns/1ps
`include "token_engine_macros.svh"

module lane_mac_array (
    input  logic                               clk,
    input  logic                               rst_i,
    input  logic                               clear_i,
    input  logic                               wgt_we_i,
    input  logic [$clog2(`NUM_LANES)-1:0]      wgt_lane_i,
    input  logic [`GLB_DW-1:0]                 wgt_data_i,
    input  logic                               acc_en_i,
    input  logic [`GLB_DW-1:0]                 acc_data_i,
    input  logic [`NUM_LANES-1:0][1:0]         byte_select_i,
    output logic [`NUM_LANES-1:0][`GLB_DW-1:0] acc_o
);

    logic [7:0]                   wgt_q [`NUM_LANES];
    logic [`NUM_LANES-1:0][15:0]  prod;

    // only the low byte of a weight word is kept
    always_ff @(posedge clk) begin
        if (wgt_we_i) begin
            wgt_q[wgt_lane_i] <= wgt_data_i[7:0];
        end
    end

    always_comb begin
        for (int l = 0; l < `NUM_LANES; l++) begin
            prod[l] = wgt_q[l] * acc_data_i[{byte_select_i[l], 3'b000} +: 8];
        end
    end

    // 32-bit accumulators wrap on overflow
    always_ff @(posedge clk) begin
        if (rst_i || clear_i) begin
            acc_o <= '0;
        end else if (acc_en_i) begin
            for (int l = 0; l < `NUM_LANES; l++) begin
                acc_o[l] <= acc_o[l] + prod[l];
            end
        end
    end

endmodule

// File: verilog/glb_request_tracker.sv
`timescale 1ns/1ps
`include "token_engine_macros.svh"

module glb_request_tracker
    import glb_bus_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst_i,
    input  logic                          issue_valid_i,
    output logic                          issue_ready_o,
    input  glb_req_t                      issue_req_i,
    input  rsp_tag_e                      issue_tag_i,
    output logic                          glb_req_valid_o,
    input  logic                          glb_req_ready_i,
    output glb_req_t                      glb_req_o,
    input  logic                          glb_rsp_valid_i,
    input  glb_rsp_t                      glb_rsp_i,
    output logic                          wgt_we_o,
    output logic [$clog2(`NUM_LANES)-1:0] wgt_lane_o,
    output logic [`GLB_DW-1:0]            wgt_data_o,
    output logic                          acc_en_o,
    output logic [`GLB_DW-1:0]            acc_data_o,
    output logic                          idle_o
);

    localparam int PTR_W = $clog2(`MAX_OUTSTANDING);
    localparam int OST_W = $clog2(`MAX_OUTSTANDING + 1);

    rsp_tag_e                      tag_q [`MAX_OUTSTANDING];
    logic [PTR_W-1:0]              wr_ptr_q;
    logic [PTR_W-1:0]              rd_ptr_q;
    logic [OST_W-1:0]              ost_q;     // reads in flight
    logic [$clog2(`NUM_LANES)-1:0] wlane_q;   // next lane to get a weight
    logic                          can_issue;
    logic                          rd_fire;
    rsp_tag_e                      head_tag;

    // writes never wait on the read credit
    assign can_issue       = issue_req_i.we || (ost_q < `MAX_OUTSTANDING);
    assign glb_req_valid_o = issue_valid_i && can_issue;
    assign issue_ready_o   = glb_req_ready_i && can_issue;
    assign glb_req_o       = issue_req_i;
    assign rd_fire         = glb_req_valid_o && glb_req_ready_i && !issue_req_i.we;

    assign head_tag = tag_q[rd_ptr_q];   // responses come back in order

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            tag_q[wr_ptr_q] <= issue_tag_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            ost_q    <= '0;
            wlane_q  <= '0;
        end else begin
            if (rd_fire) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (glb_rsp_valid_i) rd_ptr_q <= rd_ptr_q + 1'b1;
            if (wgt_we_o) wlane_q <= wlane_q + 1'b1;   // wraps once per pass
            case ({rd_fire, glb_rsp_valid_i})
                2'b10: ost_q <= ost_q + 1'b1;
                2'b01: ost_q <= ost_q - 1'b1;
                default: begin
                end
            endcase
        end
    end

    // response goes straight to the lanes
    assign wgt_we_o   = glb_rsp_valid_i && (head_tag == TAG_WEIGHT);
    assign wgt_lane_o = wlane_q;
    assign wgt_data_o = glb_rsp_i.rdata;
    assign acc_en_o   = glb_rsp_valid_i && (head_tag == TAG_STREAM);
    assign acc_data_o = glb_rsp_i.rdata;
    assign idle_o     = (ost_q == '0);

    a_no_stray_rsp: assert property (@(posedge clk) disable iff (rst_i)
        glb_rsp_valid_i |-> ost_q != '0);

    a_no_overflow: assert property (@(posedge clk) disable iff (rst_i)
        ost_q <= `MAX_OUTSTANDING);

endmodule

// File: verilog/token_engine.sv
`timescale 1ns/1ps
`include "token_engine_macros.svh"

module token_engine
    import engine_cfg_pkg::*;
    import glb_bus_pkg::*;
(
    input  logic      clk,
    input  logic      rst_i,
    input  logic      cmd_valid_i,
    output logic      cmd_ready_o,
    input  pass_cmd_t cmd_i,
    output logic      glb_req_valid_o,
    input  logic      glb_req_ready_i,
    output glb_req_t  glb_req_o,
    input  logic      glb_rsp_valid_i,
    input  glb_rsp_t  glb_rsp_i,
    output logic      pass_done_o
);

    pass_cfg_t                          cfg;
    logic                               start;
    logic                               busy;
    logic [`NUM_LANES-1:0][`GLB_DW-1:0] acc;
    logic                               clear_acc;

    // sequencer to tracker
    logic                               issue_valid;
    logic                               issue_ready;
    glb_req_t                           issue_req;
    rsp_tag_e                           issue_tag;
    logic                               tracker_idle;

    // tracker to lanes
    logic                               wgt_we;
    logic [$clog2(`NUM_LANES)-1:0]      wgt_lane;
    logic [`GLB_DW-1:0]                 wgt_data;
    logic                               acc_en;
    logic [`GLB_DW-1:0]                 acc_data;

    pass_decoder u_pass_decoder (
        .clk         (clk),
        .rst_i       (rst_i),
        .cmd_valid_i (cmd_valid_i),
        .cmd_ready_o (cmd_ready_o),
        .cmd_i       (cmd_i),
        .busy_i      (busy),
        .cfg_o       (cfg),
        .start_o     (start)
    );

    phase_sequencer u_phase_sequencer (
        .clk            (clk),
        .rst_i          (rst_i),
        .start_i        (start),
        .cfg_i          (cfg),
        .acc_i          (acc),
        .tracker_idle_i (tracker_idle),
        .issue_valid_o  (issue_valid),
        .issue_ready_i  (issue_ready),
        .issue_req_o    (issue_req),
        .issue_tag_o    (issue_tag),
        .clear_acc_o    (clear_acc),
        .busy_o         (busy),
        .pass_done_o    (pass_done_o)
    );

    lane_mac_array u_lane_mac_array (
        .clk           (clk),
        .rst_i         (rst_i),
        .clear_i       (clear_acc),
        .wgt_we_i      (wgt_we),
        .wgt_lane_i    (wgt_lane),
        .wgt_data_i    (wgt_data),
        .acc_en_i      (acc_en),
        .acc_data_i    (acc_data),
        .byte_select_i (cfg.byte_select),
        .acc_o         (acc)
    );

    glb_request_tracker u_glb_request_tracker (
        .clk             (clk),
        .rst_i           (rst_i),
        .issue_valid_i   (issue_valid),
        .issue_ready_o   (issue_ready),
        .issue_req_i     (issue_req),
        .issue_tag_i     (issue_tag),
        .glb_req_valid_o (glb_req_valid_o),
        .glb_req_ready_i (glb_req_ready_i),
        .glb_req_o       (glb_req_o),
        .glb_rsp_valid_i (glb_rsp_valid_i),
        .glb_rsp_i       (glb_rsp_i),
        .wgt_we_o        (wgt_we),
        .wgt_lane_o      (wgt_lane),
        .wgt_data_o      (wgt_data),
        .acc_en_o        (acc_en),
        .acc_data_o      (acc_data),
        .idle_o          (tracker_idle)
    );

endmodule

// File: test/tb_glb_model.sv
`timescale 1ns/1ps
`include "token_engine_macros.svh"

module tb_glb_model
    import glb_bus_pkg::*;
(
    input  logic       clk,
    input  logic       rst_i,
    input  logic       req_valid_i,
    input  logic       req_ready_i,    // random ready comes from the testbench
    input  glb_req_t   req_i,
    input  logic [2:0] lat_i,          // cycles until this read returns
    output logic       rsp_valid_o = 1'b0,
    output glb_rsp_t   rsp_o = '0
);

    logic [`GLB_AW-1:0] rd_addr_q[$];   // every accepted read in order
    logic [`GLB_AW-1:0] wr_addr_q[$];
    logic [`GLB_AW-1:0] pend_addr_q[$];
    int                 pend_due_q[$];
    int                 cycle;
    int                 ost;            // reads accepted but not yet taken back
    int                 max_ost;

    // every byte of the memory depends on the whole address
    function automatic logic [`GLB_DW-1:0] word_at(input logic [`GLB_AW-1:0] addr);
        logic [31:0] x;
        x = {16'h0000, addr} * 32'h9e37_79b1 + 32'h7f4a_7c15;
        x = x ^ (x >> 13);
        return x;
    endfunction

    always @(posedge clk) begin
        if (rst_i) begin
            rsp_valid_o <= 1'b0;
            rsp_o       <= '0;
            pend_addr_q.delete();
            pend_due_q.delete();
            cycle   = 0;
            ost     = 0;
            max_ost = 0;
        end else begin
            cycle = cycle + 1;
            if (rsp_valid_o) ost = ost - 1;   // DUT takes it at this edge
            if (req_valid_i && req_ready_i) begin
                if (req_i.we) begin
                    wr_addr_q.push_back(req_i.addr);
                end else begin
                    rd_addr_q.push_back(req_i.addr);
                    pend_addr_q.push_back(req_i.addr);
                    pend_due_q.push_back(cycle + ((lat_i == 3'd0) ? 1 : int'(lat_i)));
                    ost = ost + 1;
                end
            end
            if (ost > max_ost) max_ost = ost;
            // a slow head holds back faster reads behind it
            if (pend_due_q.size() > 0 && pend_due_q[0] <= cycle) begin
                rsp_valid_o <= 1'b1;
                rsp_o.rdata <= word_at(pend_addr_q.pop_front());
                void'(pend_due_q.pop_front());
            end else begin
                rsp_valid_o <= 1'b0;
            end
        end
    end

endmodule

// File: test/tb_token_engine.sv
`timescale 1ns/1ps
`include "token_engine_macros.svh"

module tb_token_engine
    import engine_cfg_pkg::*;
    import glb_bus_pkg::*;
();

    localparam logic [31:0] SEED       = 32'ha643;
    localparam int          WAIT_LIMIT = 4000;
    localparam int          AW         = `GLB_AW;

    logic       clk;
    logic       rst;
    logic       cmd_valid;
    pass_cmd_t  cmd;
    logic       cmd_ready;
    logic       glb_req_valid;
    glb_req_t   glb_req;
    logic       glb_ready = 1'b1;
    logic [2:0] lat = 3'd1;
    logic       glb_rsp_valid;
    glb_rsp_t   glb_rsp;
    logic       pass_done;
    logic       stall_en;

    logic [31:0]        cmd_rng = SEED;
    logic [31:0]        bp_rng  = ~SEED;   // separate stream for the GLB side
    logic [`GLB_AW-1:0] exp_rd_q[$];
    logic [`GLB_AW-1:0] exp_wr_addr_q[$];
    logic [`GLB_DW-1:0] exp_wr_data_q[$];
    int                 err_cnt  = 0;
    int                 test_cnt = 0;
    int                 fail_cnt = 0;
    int                 test_err_base = 0;

    token_engine dut_i (
        .clk             (clk),
        .rst_i           (rst),
        .cmd_valid_i     (cmd_valid),
        .cmd_ready_o     (cmd_ready),
        .cmd_i           (cmd),
        .glb_req_valid_o (glb_req_valid),
        .glb_req_ready_i (glb_ready),
        .glb_req_o       (glb_req),
        .glb_rsp_valid_i (glb_rsp_valid),
        .glb_rsp_i       (glb_rsp),
        .pass_done_o     (pass_done)
    );

    tb_glb_model glb_i (
        .clk         (clk),
        .rst_i       (rst),
        .req_valid_i (glb_req_valid),
        .req_ready_i (glb_ready),
        .req_i       (glb_req),
        .lat_i       (lat),
        .rsp_valid_o (glb_rsp_valid),
        .rsp_o       (glb_rsp)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // GLB ready and read latency
    always @(posedge clk) begin
        if (stall_en) begin
            bp_rng = lcg_next(bp_rng);
            glb_ready <= (bp_rng[17:16] != 2'b00);   // ready about 3 cycles in 4
            lat       <= 3'd1 + 3'(bp_rng[25:24]) + 3'(bp_rng[28]);
        end else begin
            glb_ready <= 1'b1;
            lat       <= 3'd1;
        end
    end

    task automatic mismatch_seen(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        err_cnt++;
    endtask

    task automatic protocol_fault(input string msg);
        $display("%s", msg);
        err_cnt++;
    endtask

    task automatic stop_on_timeout(input string what);
        $display("gave up after %0d cycles: %s", WAIT_LIMIT, what);
        $display("Test failures found");
        $finish;
    endtask

    function automatic int stream_len(input pass_cmd_t c);
        if (c.desc.fc.kind == LAYER_FC) return int'(c.desc.fc.in_len);
        return int'(c.desc.conv.in_c) * int'(c.desc.conv.in_r);
    endfunction

    function automatic logic [`NUM_LANES-1:0] ref_mask(input pass_cmd_t c);
        logic [`NUM_LANES-1:0] m;
        for (int l = 0; l < `NUM_LANES; l++) begin
            m[l] = (l < int'(c.desc.conv.oc_real));
        end
        return m;
    endfunction

    // expected lane sums from the GLB contents
    function automatic logic [`NUM_LANES-1:0][`GLB_DW-1:0] ref_sums(input pass_cmd_t c);
        logic [`NUM_LANES-1:0][`GLB_DW-1:0] sums;
        logic [`NUM_LANES-1:0][7:0]         wgt;
        logic [`GLB_DW-1:0]                 word;
        logic [7:0]                         act;
        logic [`GLB_AW-1:0]                 addr;
        sums = '0;
        for (int l = 0; l < `NUM_LANES; l++) begin
            addr   = c.weight_base + AW'(l);
            word   = glb_i.word_at(addr);
            wgt[l] = word[7:0];
        end
        for (int i = 0; i < stream_len(c); i++) begin
            addr = c.ifmap_base + AW'(i);
            word = glb_i.word_at(addr);
            for (int l = 0; l < `NUM_LANES; l++) begin
                act = (c.desc.fc.kind == LAYER_FC) ? word[7:0] : word[8*l +: 8];
                sums[l] = sums[l] + wgt[l] * act;
            end
        end
        return sums;
    endfunction

    function automatic pass_cmd_t make_cmd(input layer_kind_e kind, input int len_a,
                                           input int len_b, input int oc,
                                           input logic [`GLB_AW-1:0] base);
        pass_cmd_t c;
        c = '0;
        if (kind == LAYER_FC) begin
            c.desc.fc.kind    = LAYER_FC;
            c.desc.fc.oc_real = 4'(oc);
            c.desc.fc.in_len  = 16'(len_a);
        end else begin
            c.desc.conv.kind    = LAYER_CONV;
            c.desc.conv.oc_real = 4'(oc);
            c.desc.conv.in_c    = 8'(len_a);
            c.desc.conv.in_r    = 8'(len_b);
        end
        c.weight_base = base;
        c.ifmap_base  = base + 16'h0100;
        c.opsum_base  = base + 16'h0800;
        return c;
    endfunction

    task automatic random_cmd(output pass_cmd_t c);
        logic [`GLB_AW-1:0] base;
        cmd_rng = lcg_next(cmd_rng);
        base    = {cmd_rng[31:28], 12'h000};
        if (cmd_rng[16]) begin
            c = make_cmd(LAYER_FC, 1 + int'(cmd_rng[23:20]), 0, int'(cmd_rng[26:24]), base);
        end else begin
            c = make_cmd(LAYER_CONV, 1 + int'(cmd_rng[19:18]), 1 + int'(cmd_rng[21:20]),
                         int'(cmd_rng[26:24]), base);
        end
    endtask

    // checks each GLB handshake just before the edge that takes it
    always @(negedge clk) begin
        if (!rst && glb_req_valid && glb_ready) begin
            if (glb_req.we) begin
                assert (exp_wr_addr_q.size() > 0) else
                    protocol_fault($sformatf("write to %h arrived with no write expected",
                                             glb_req.addr));
                if (exp_wr_addr_q.size() > 0) begin
                    assert (glb_req.addr == exp_wr_addr_q[0] &&
                            glb_req.wdata == exp_wr_data_q[0]) else
                        mismatch_seen($sformatf("write %h=%h, expected %h=%h", glb_req.addr,
                                      glb_req.wdata, exp_wr_addr_q[0], exp_wr_data_q[0]));
                    void'(exp_wr_addr_q.pop_front());
                    void'(exp_wr_data_q.pop_front());
                end
            end else begin
                assert (exp_rd_q.size() > 0) else
                    protocol_fault($sformatf("read of %h arrived with no read expected",
                                             glb_req.addr));
                if (exp_rd_q.size() > 0) begin
                    assert (glb_req.addr == exp_rd_q[0]) else
                        mismatch_seen($sformatf("read address %h, expected %h",
                                                glb_req.addr, exp_rd_q[0]));
                    void'(exp_rd_q.pop_front());
                end
            end
        end
    end

    task automatic run_pass(input pass_cmd_t c);
        logic [`NUM_LANES-1:0][`GLB_DW-1:0] sums;
        logic [`NUM_LANES-1:0]              mask;
        int                                 rd_base;
        int                                 wr_base;
        int                                 n_rd;
        int                                 n_wr;
        int                                 cycles;
        sums = ref_sums(c);
        mask = ref_mask(c);
        n_rd = `NUM_LANES + stream_len(c);
        n_wr = 0;
        for (int l = 0; l < `NUM_LANES; l++) begin
            exp_rd_q.push_back(c.weight_base + AW'(l));
            if (mask[l]) begin   // ascending lane order
                exp_wr_addr_q.push_back(c.opsum_base + AW'(l));
                exp_wr_data_q.push_back(sums[l]);
                n_wr++;
            end
        end
        for (int i = 0; i < stream_len(c); i++) begin
            exp_rd_q.push_back(c.ifmap_base + AW'(i));
        end
        rd_base = glb_i.rd_addr_q.size();
        wr_base = glb_i.wr_addr_q.size();

        @(posedge clk);
        cmd_valid <= 1'b1;
        cmd       <= c;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!cmd_ready && cycles < WAIT_LIMIT);
        if (!cmd_ready) stop_on_timeout("the engine never became ready for a command");
        @(posedge clk);
        cmd_valid <= 1'b0;

        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            assert (!cmd_ready) else protocol_fault("cmd_ready was high during a pass");
        end while (!pass_done && cycles < WAIT_LIMIT);
        if (!pass_done) stop_on_timeout("the pass never signalled pass_done");

        @(negedge clk);
        assert (cmd_ready) else protocol_fault("cmd_ready stayed low after pass_done");
        assert (exp_rd_q.size() == 0 && exp_wr_addr_q.size() == 0) else
            protocol_fault("some expected GLB requests never appeared");
        assert (glb_i.rd_addr_q.size() - rd_base == n_rd) else
            mismatch_seen($sformatf("%0d reads issued, expected %0d",
                                    glb_i.rd_addr_q.size() - rd_base, n_rd));
        assert (glb_i.wr_addr_q.size() - wr_base == n_wr) else
            mismatch_seen($sformatf("%0d writes issued, expected %0d",
                                    glb_i.wr_addr_q.size() - wr_base, n_wr));
        assert (glb_i.max_ost <= `MAX_OUTSTANDING) else
            mismatch_seen($sformatf("%0d reads were in flight at once", glb_i.max_ost));
        exp_rd_q.delete();
        exp_wr_addr_q.delete();
        exp_wr_data_q.delete();
    endtask

    task automatic finish_test(input string name);
        test_cnt++;
        if (err_cnt == test_err_base) begin
            $display("test %0d %s: passed", test_cnt, name);
        end else begin
            fail_cnt++;
            $display("test %0d %s: FAILED, %0d errors", test_cnt, name, err_cnt - test_err_base);
        end
        test_err_base = err_cnt;
    endtask

    initial begin
        pass_cmd_t c;
        rst       = 1'b1;
        cmd_valid = 1'b0;
        cmd       = '0;
        stall_en  = 1'b0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);

        assert (cmd_ready === 1'b1 && glb_req_valid === 1'b0 && pass_done === 1'b0) else
            mismatch_seen($sformatf("after reset ready=%b req_valid=%b done=%b",
                                    cmd_ready, glb_req_valid, pass_done));
        finish_test("reset state");

        run_pass(make_cmd(LAYER_CONV, 3, 2, 4, 16'h0100));
        finish_test("conv pass");

        run_pass(make_cmd(LAYER_FC, 12, 0, 9, 16'h2000));   // oc_real saturates
        finish_test("fc pass");

        run_pass(make_cmd(LAYER_CONV, 2, 3, 2, 16'h3000));
        run_pass(make_cmd(LAYER_FC, 5, 0, 0, 16'h3400));    // nothing to write back
        finish_test("lane masking");

        @(posedge clk);
        stall_en <= 1'b1;
        for (int i = 0; i < 8; i++) begin
            random_cmd(c);
            run_pass(c);
        end
        finish_test("random back-pressure");

        @(posedge clk);
        stall_en <= 1'b0;
        run_pass(make_cmd(LAYER_CONV, 4, 4, 3, 16'h5000));
        run_pass(make_cmd(LAYER_FC, 7, 0, 4, 16'h6000));
        finish_test("back-to-back passes");

        $display("tests run %0d, tests failed %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0 && fail_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+verilog
verilog/engine_cfg_pkg.sv
verilog/glb_bus_pkg.sv
verilog/pass_decoder.sv
verilog/phase_sequencer.sv
verilog/lane_mac_array.sv
verilog/glb_request_tracker.sv
verilog/token_engine.sv
test/tb_glb_model.sv
test/tb_token_engine.sv

// File: Bender.yml
package:
  name: token_engine

export_include_dirs:
  - verilog

sources:
  - files:
      - verilog/engine_cfg_pkg.sv
      - verilog/glb_bus_pkg.sv
      - verilog/pass_decoder.sv
      - verilog/phase_sequencer.sv
      - verilog/lane_mac_array.sv
      - verilog/glb_request_tracker.sv
      - verilog/token_engine.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - test/tb_glb_model.sv
      - test/tb_token_engine.sv
